// ==== source/bm_pkg.sv ====
/*
 * Buffer manager shared definitions
 * Bus and pointer widths, pool size
 * Register offsets of the PIO port
 * Buffer pointer and PIO word types
 */

package bm_pkg;

	// PIO bus width for address and data
	localparam int pio_nbits = 32;

	// Buffer pointers and access counters
	localparam int buf_ptr_nbits = 8;
	localparam int num_bufs = 256;

	// Free count needs one extra bit to hold a full pool
	localparam int free_cnt_nbits = buf_ptr_nbits + 1;

	// Admission shift factor
	localparam int dt_alpha_nbits = 4;

	// Low address bits seen by the register decoder
	localparam int bm_reg_addr_nbits = 3;

	typedef logic [buf_ptr_nbits-1:0] buf_ptr_t;
	typedef logic [pio_nbits-1:0] pio_word_t;

	// Register map
	// Offset 0 holds init command in bit 0, init done in bit 31
	localparam logic [bm_reg_addr_nbits-1:0] bm_freeb_init = 3'd0;

	// Read-only wrapping counters
	localparam logic [bm_reg_addr_nbits-1:0] bm_freeb_rd_count = 3'd1;
	localparam logic [bm_reg_addr_nbits-1:0] bm_freeb_wr_count = 3'd2;
	localparam logic [bm_reg_addr_nbits-1:0] bm_ll_rd_count = 3'd3;
	localparam logic [bm_reg_addr_nbits-1:0] bm_ll_wr_count = 3'd4;

	// Threshold shift for allocation admission
	localparam logic [bm_reg_addr_nbits-1:0] bm_dt_alpha = 3'd5;

endpackage

// ==== source/bm_reg.sv ====
/*
 * PIO register block of the buffer manager
 * Address decode and read multiplexer
 * Init command and alpha registers
 * Free-list and link-list access counters
 */

module bm_reg (
	input  logic clk,
	input  logic reset,
	input  logic clk_div,

	input  logic reg_bs,
	input  logic reg_rd,
	input  logic reg_wr,
	input  bm_pkg::pio_word_t reg_addr,
	input  bm_pkg::pio_word_t reg_din,

	output logic pio_ack,
	output logic pio_rvalid,
	output bm_pkg::pio_word_t pio_rdata,

	input  logic freeb_init_done,
	input  logic inc_freeb_rd_count,
	input  logic inc_freeb_wr_count,
	input  logic inc_ll_rd_count,
	input  logic inc_ll_wr_count,

	output logic freeb_init,
	output logic [bm_pkg::dt_alpha_nbits-1:0] dt_alpha
);

	localparam int cnt_pad = bm_pkg::pio_nbits - bm_pkg::buf_ptr_nbits;

	bm_pkg::buf_ptr_t freeb_rd_count;
	bm_pkg::buf_ptr_t freeb_wr_count;
	bm_pkg::buf_ptr_t ll_rd_count;
	bm_pkg::buf_ptr_t ll_wr_count;

	logic req;
	logic req_seen;
	logic start;
	logic ack_pend;
	logic rd_pend;

	logic mapped;
	logic sel_freeb_init;
	logic sel_dt_alpha;

	// An access starts once, on the first cycle the request shows up
	assign req = reg_bs & (reg_rd | reg_wr);
	assign start = req & ~req_seen;

	always_comb begin
		mapped = 1'b1;
		sel_freeb_init = 1'b0;
		sel_dt_alpha = 1'b0;
		pio_rdata = '0;

		case (reg_addr[bm_pkg::bm_reg_addr_nbits-1:0])
			bm_pkg::bm_freeb_init: begin
				sel_freeb_init = 1'b1;
				pio_rdata = {freeb_init_done, {(bm_pkg::pio_nbits-2){1'b0}}, freeb_init};
			end
			bm_pkg::bm_freeb_rd_count: begin
				pio_rdata = {{cnt_pad{1'b0}}, freeb_rd_count};
			end
			bm_pkg::bm_freeb_wr_count: begin
				pio_rdata = {{cnt_pad{1'b0}}, freeb_wr_count};
			end
			bm_pkg::bm_ll_rd_count: begin
				pio_rdata = {{cnt_pad{1'b0}}, ll_rd_count};
			end
			bm_pkg::bm_ll_wr_count: begin
				pio_rdata = {{cnt_pad{1'b0}}, ll_wr_count};
			end
			bm_pkg::bm_dt_alpha: begin
				sel_dt_alpha = 1'b1;
				pio_rdata = {{(bm_pkg::pio_nbits-bm_pkg::dt_alpha_nbits){1'b0}}, dt_alpha};
			end
			default: mapped = 1'b0;
		endcase
	end

	// Access handshake, paced by the slow bus strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			req_seen <= 1'b0;
			ack_pend <= 1'b0;
			rd_pend <= 1'b0;
			pio_ack <= 1'b0;
			pio_rvalid <= 1'b0;
		end else begin
			req_seen <= req;
			pio_rvalid <= clk_div & rd_pend;
			pio_ack <= clk_div & ack_pend & ~rd_pend;

			if (start) begin
				ack_pend <= 1'b1;
				rd_pend <= reg_rd & mapped;
			end else begin
				// Read data goes out first, ack on a later strobe
				if (clk_div & rd_pend)
					rd_pend <= 1'b0;
				if (clk_div & ack_pend & ~rd_pend)
					ack_pend <= 1'b0;
			end
		end
	end

	// Writable control bits
	always_ff @(posedge clk) begin
		if (reset) begin
			freeb_init <= 1'b0;
			dt_alpha <= '0;
		end else if (start & reg_wr) begin
			if (sel_freeb_init)
				freeb_init <= reg_din[0];
			if (sel_dt_alpha)
				dt_alpha <= reg_din[bm_pkg::dt_alpha_nbits-1:0];
		end
	end

	// Counters wrap at the pointer width
	always_ff @(posedge clk) begin
		if (reset) begin
			freeb_rd_count <= '0;
			freeb_wr_count <= '0;
			ll_rd_count <= '0;
			ll_wr_count <= '0;
		end else begin
			freeb_rd_count <= freeb_rd_count + bm_pkg::buf_ptr_t'(inc_freeb_rd_count);
			freeb_wr_count <= freeb_wr_count + bm_pkg::buf_ptr_t'(inc_freeb_wr_count);
			ll_rd_count <= ll_rd_count + bm_pkg::buf_ptr_t'(inc_ll_rd_count);
			ll_wr_count <= ll_wr_count + bm_pkg::buf_ptr_t'(inc_ll_wr_count);
		end
	end

endmodule

// ==== source/bm_freeb_list.sv ====
/*
 * Free-buffer list
 * Pointer FIFO with head, tail and free count
 * Init sequencer that loads every pointer once
 * Dynamic threshold admission for allocation
 */

module bm_freeb_list (
	input  logic clk,
	input  logic reset,

	input  logic freeb_init,
	input  logic [bm_pkg::dt_alpha_nbits-1:0] dt_alpha,
	output logic freeb_init_done,

	input  logic alloc_req,
	input  bm_pkg::buf_ptr_t alloc_occupancy,
	output logic alloc_valid,
	output logic alloc_fail,
	output bm_pkg::buf_ptr_t alloc_ptr,

	input  logic free_req,
	input  bm_pkg::buf_ptr_t free_ptr,

	output logic inc_freeb_rd_count,
	output logic inc_freeb_wr_count
);

	localparam logic [bm_pkg::free_cnt_nbits-1:0] full_cnt =
		bm_pkg::free_cnt_nbits'(bm_pkg::num_bufs);
	localparam bm_pkg::buf_ptr_t last_ptr = bm_pkg::buf_ptr_t'(bm_pkg::num_bufs - 1);

	bm_pkg::buf_ptr_t mem [bm_pkg::num_bufs];

	bm_pkg::buf_ptr_t head;
	bm_pkg::buf_ptr_t tail;
	logic [bm_pkg::free_cnt_nbits-1:0] free_cnt;
	logic [bm_pkg::free_cnt_nbits-1:0] threshold;

	logic init_d;
	logic init_rise;
	logic init_busy;
	bm_pkg::buf_ptr_t init_ptr;

	logic grant;
	logic accept;

	assign init_rise = freeb_init & ~init_d;

	// Requester must sit strictly below free count >> alpha
	assign threshold = free_cnt >> dt_alpha;
	assign grant = alloc_req & freeb_init_done & (free_cnt != '0) &
		({1'b0, alloc_occupancy} < threshold);

	// Frees only land on a ready list that has room
	assign accept = free_req & freeb_init_done & (free_cnt != full_cnt);

	assign inc_freeb_rd_count = grant;
	assign inc_freeb_wr_count = accept;

	// Pointer storage
	always_ff @(posedge clk) begin
		if (init_busy)
			mem[tail] <= init_ptr;
		else if (accept)
			mem[tail] <= free_ptr;
	end

	// Head entry is valid whenever a grant is possible
	always_ff @(posedge clk) begin
		if (grant)
			alloc_ptr <= mem[head];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			alloc_valid <= 1'b0;
			alloc_fail <= 1'b0;
		end else begin
			alloc_valid <= grant;
			alloc_fail <= alloc_req & ~grant;
		end
	end

	// Init sequencer and FIFO pointers
	always_ff @(posedge clk) begin
		if (reset) begin
			init_d <= 1'b0;
			init_busy <= 1'b0;
			init_ptr <= '0;
			freeb_init_done <= 1'b0;
			head <= '0;
			tail <= '0;
			free_cnt <= '0;
		end else begin
			init_d <= freeb_init;

			if (!freeb_init) begin
				// Dropping the command abandons the list
				init_busy <= 1'b0;
				freeb_init_done <= 1'b0;
			end else if (init_rise) begin
				init_busy <= 1'b1;
				init_ptr <= '0;
				freeb_init_done <= 1'b0;
				head <= '0;
				tail <= '0;
				free_cnt <= '0;
			end else if (init_busy) begin
				tail <= tail + 1'b1;
				free_cnt <= free_cnt + 1'b1;
				init_ptr <= init_ptr + 1'b1;
				if (init_ptr == last_ptr) begin
					init_busy <= 1'b0;
					freeb_init_done <= 1'b1;
				end
			end else begin
				if (grant)
					head <= head + 1'b1;
				if (accept)
					tail <= tail + 1'b1;
				free_cnt <= free_cnt + {{(bm_pkg::free_cnt_nbits-1){1'b0}}, accept}
					- {{(bm_pkg::free_cnt_nbits-1){1'b0}}, grant};
			end
		end
	end

endmodule

// ==== source/bm_link_list.sv ====
/*
 * Link-list memory
 * One next pointer per buffer
 * Write port and registered read port
 */

module bm_link_list (
	input  logic clk,
	input  logic reset,

	input  logic ll_wr,
	input  bm_pkg::buf_ptr_t ll_wr_ptr,
	input  bm_pkg::buf_ptr_t ll_wr_next,

	input  logic ll_rd,
	input  bm_pkg::buf_ptr_t ll_rd_ptr,
	output logic ll_rd_valid,
	output bm_pkg::buf_ptr_t ll_rd_next,

	output logic inc_ll_rd_count,
	output logic inc_ll_wr_count
);

	bm_pkg::buf_ptr_t next_mem [bm_pkg::num_bufs];

	// Every access is counted by the register block
	assign inc_ll_rd_count = ll_rd;
	assign inc_ll_wr_count = ll_wr;

	always_ff @(posedge clk) begin
		if (ll_wr)
			next_mem[ll_wr_ptr] <= ll_wr_next;
	end

	// Same-address write in the read cycle lands after the read
	always_ff @(posedge clk) begin
		if (ll_rd)
			ll_rd_next <= next_mem[ll_rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (reset)
			ll_rd_valid <= 1'b0;
		else
			ll_rd_valid <= ll_rd;
	end

endmodule

// ==== source/bm_top.sv ====
/*
 * Buffer manager top level
 * Register block, free-buffer list and link list
 */

module bm_top (
	input  logic clk,
	input  logic reset,

	// PIO port
	input  logic clk_div,
	input  logic reg_bs,
	input  logic reg_rd,
	input  logic reg_wr,
	input  bm_pkg::pio_word_t reg_addr,
	input  bm_pkg::pio_word_t reg_din,
	output logic pio_ack,
	output logic pio_rvalid,
	output bm_pkg::pio_word_t pio_rdata,

	// Allocation and release
	input  logic alloc_req,
	input  bm_pkg::buf_ptr_t alloc_occupancy,
	output logic alloc_valid,
	output logic alloc_fail,
	output bm_pkg::buf_ptr_t alloc_ptr,
	input  logic free_req,
	input  bm_pkg::buf_ptr_t free_ptr,

	// Link list
	input  logic ll_wr,
	input  bm_pkg::buf_ptr_t ll_wr_ptr,
	input  bm_pkg::buf_ptr_t ll_wr_next,
	input  logic ll_rd,
	input  bm_pkg::buf_ptr_t ll_rd_ptr,
	output logic ll_rd_valid,
	output bm_pkg::buf_ptr_t ll_rd_next
);

	logic freeb_init;
	logic freeb_init_done;
	logic [bm_pkg::dt_alpha_nbits-1:0] dt_alpha;

	logic inc_freeb_rd_count;
	logic inc_freeb_wr_count;
	logic inc_ll_rd_count;
	logic inc_ll_wr_count;

	bm_reg bm_reg_inst (
		.clk                (clk),
		.reset              (reset),
		.clk_div            (clk_div),
		.reg_bs             (reg_bs),
		.reg_rd             (reg_rd),
		.reg_wr             (reg_wr),
		.reg_addr           (reg_addr),
		.reg_din            (reg_din),
		.pio_ack            (pio_ack),
		.pio_rvalid         (pio_rvalid),
		.pio_rdata          (pio_rdata),
		.freeb_init_done    (freeb_init_done),
		.inc_freeb_rd_count (inc_freeb_rd_count),
		.inc_freeb_wr_count (inc_freeb_wr_count),
		.inc_ll_rd_count    (inc_ll_rd_count),
		.inc_ll_wr_count    (inc_ll_wr_count),
		.freeb_init         (freeb_init),
		.dt_alpha           (dt_alpha)
	);

	bm_freeb_list bm_freeb_list_inst (
		.clk                (clk),
		.reset              (reset),
		.freeb_init         (freeb_init),
		.dt_alpha           (dt_alpha),
		.freeb_init_done    (freeb_init_done),
		.alloc_req          (alloc_req),
		.alloc_occupancy    (alloc_occupancy),
		.alloc_valid        (alloc_valid),
		.alloc_fail         (alloc_fail),
		.alloc_ptr          (alloc_ptr),
		.free_req           (free_req),
		.free_ptr           (free_ptr),
		.inc_freeb_rd_count (inc_freeb_rd_count),
		.inc_freeb_wr_count (inc_freeb_wr_count)
	);

	bm_link_list bm_link_list_inst (
		.clk             (clk),
		.reset           (reset),
		.ll_wr           (ll_wr),
		.ll_wr_ptr       (ll_wr_ptr),
		.ll_wr_next      (ll_wr_next),
		.ll_rd           (ll_rd),
		.ll_rd_ptr       (ll_rd_ptr),
		.ll_rd_valid     (ll_rd_valid),
		.ll_rd_next      (ll_rd_next),
		.inc_ll_rd_count (inc_ll_rd_count),
		.inc_ll_wr_count (inc_ll_wr_count)
	);

endmodule

// ==== bench/bm_tb.sv ====
/*
 * Testbench for the buffer manager
 * Clock, reset and slow bus strobe
 * Trace reader for PIO, allocation, free and link-list operations
 * Typed compare tasks, error count and run limit
 */

module bm_tb;

	// Init fill twice, one full drain and about 40 other operations of up to 20 cycles
	localparam int max_cycles = 2000;
	localparam int ack_limit = 20;
	localparam int init_polls = 100;

	logic clk;
	logic reset;
	logic clk_div;
	logic reg_bs;
	logic reg_rd;
	logic reg_wr;
	bm_pkg::pio_word_t reg_addr;
	bm_pkg::pio_word_t reg_din;
	logic pio_ack;
	logic pio_rvalid;
	bm_pkg::pio_word_t pio_rdata;
	logic alloc_req;
	bm_pkg::buf_ptr_t alloc_occupancy;
	logic alloc_valid;
	logic alloc_fail;
	bm_pkg::buf_ptr_t alloc_ptr;
	logic free_req;
	bm_pkg::buf_ptr_t free_ptr;
	logic ll_wr;
	bm_pkg::buf_ptr_t ll_wr_ptr;
	bm_pkg::buf_ptr_t ll_wr_next;
	logic ll_rd;
	bm_pkg::buf_ptr_t ll_rd_ptr;
	logic ll_rd_valid;
	bm_pkg::buf_ptr_t ll_rd_next;

	int errors = 0;
	int cycles = 0;
	int div_cnt = 0;

	bm_top bm_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Slow bus strobe on every third cycle
	always @(posedge clk) begin
		#1;
		div_cnt = (div_cnt == 2) ? 0 : div_cnt + 1;
		clk_div = (div_cnt == 2);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Run stopped after %0d cycles before the trace was finished", cycles);
			$display("errors: %0d", errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_pio(input string name, input bm_pkg::pio_word_t got,
		input bm_pkg::pio_word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_alloc(input logic exp_fail, input bm_pkg::buf_ptr_t exp_ptr);
		if (alloc_valid !== !exp_fail) begin
			$display("CHECK FAILED at %0t: alloc_valid got %b expected %b",
				$time, alloc_valid, !exp_fail);
			errors++;
		end
		if (alloc_fail !== exp_fail) begin
			$display("CHECK FAILED at %0t: alloc_fail got %b expected %b",
				$time, alloc_fail, exp_fail);
			errors++;
		end
		if (!exp_fail && alloc_ptr !== exp_ptr) begin
			$display("CHECK FAILED at %0t: alloc_ptr got %h expected %h",
				$time, alloc_ptr, exp_ptr);
			errors++;
		end
	endtask

	task automatic check_link(input bm_pkg::buf_ptr_t exp_next);
		if (ll_rd_valid !== 1'b1) begin
			$display("CHECK FAILED at %0t: ll_rd_valid got %b expected 1", $time, ll_rd_valid);
			errors++;
		end else if (ll_rd_next !== exp_next) begin
			$display("CHECK FAILED at %0t: ll_rd_next got %h expected %h",
				$time, ll_rd_next, exp_next);
			errors++;
		end
	endtask

	// One request held until ack, read data captured on rvalid
	task automatic pio_access(input logic is_rd, input bm_pkg::pio_word_t addr,
		input bm_pkg::pio_word_t data, output bm_pkg::pio_word_t rdata, output logic rvalid);
		int n;
		rvalid = 1'b0;
		rdata = '0;
		@(posedge clk);
		#1;
		reg_bs = 1'b1;
		reg_rd = is_rd;
		reg_wr = !is_rd;
		reg_addr = addr;
		reg_din = data;
		for (n = 0; n < ack_limit; n++) begin
			@(posedge clk);
			#1;
			if (pio_rvalid) begin
				rvalid = 1'b1;
				rdata = pio_rdata;
			end
			if (pio_ack)
				break;
		end
		if (!pio_ack) begin
			$display("No pio_ack within %0d cycles for access to offset %0h", ack_limit, addr);
			errors++;
		end
		reg_bs = 1'b0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
	endtask

	task automatic wait_init_done();
		bm_pkg::pio_word_t rd;
		logic v;
		int n;
		for (n = 0; n < init_polls; n++) begin
			pio_access(1'b1, bm_pkg::pio_word_t'(bm_pkg::bm_freeb_init), '0, rd, v);
			if (v && rd[31])
				return;
		end
		$display("Init done never showed up in offset 0 after %0d reads", init_polls);
		errors++;
	endtask

	// Result shows up exactly one cycle after the request
	task automatic alloc_once(input bm_pkg::buf_ptr_t occ, input logic exp_fail,
		input bm_pkg::buf_ptr_t exp_ptr);
		@(posedge clk);
		#1;
		alloc_req = 1'b1;
		alloc_occupancy = occ;
		@(posedge clk);
		#1;
		alloc_req = 1'b0;
		check_alloc(exp_fail, exp_ptr);
	endtask

	task automatic free_once(input bm_pkg::buf_ptr_t ptr);
		@(posedge clk);
		#1;
		free_req = 1'b1;
		free_ptr = ptr;
		@(posedge clk);
		#1;
		free_req = 1'b0;
	endtask

	task automatic link_write(input bm_pkg::buf_ptr_t ptr, input bm_pkg::buf_ptr_t next);
		@(posedge clk);
		#1;
		ll_wr = 1'b1;
		ll_wr_ptr = ptr;
		ll_wr_next = next;
		@(posedge clk);
		#1;
		ll_wr = 1'b0;
	endtask

	task automatic link_read(input bm_pkg::buf_ptr_t ptr, input bm_pkg::buf_ptr_t exp_next);
		@(posedge clk);
		#1;
		ll_rd = 1'b1;
		ll_rd_ptr = ptr;
		@(posedge clk);
		#1;
		ll_rd = 1'b0;
		check_link(exp_next);
	endtask

	initial begin
		int fd;
		int n;
		int i;
		byte op;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [8*128-1:0] skip;
		bm_pkg::pio_word_t rd;
		logic v;

		reset = 1'b1;
		clk_div = 1'b0;
		reg_bs = 1'b0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		alloc_req = 1'b0;
		alloc_occupancy = '0;
		free_req = 1'b0;
		free_ptr = '0;
		ll_wr = 1'b0;
		ll_wr_ptr = '0;
		ll_wr_next = '0;
		ll_rd = 1'b0;
		ll_rd_ptr = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		fd = $fopen("bench/bm_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file bench/bm_trace.txt");
			errors++;
		end else begin
			while ($fscanf(fd, " %c", op) == 1) begin
				case (op)
					"#": n = $fgets(skip, fd);
					"W": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						pio_access(1'b0, f1, f2, rd, v);
					end
					"R": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						pio_access(1'b1, f1, '0, rd, v);
						if (!v) begin
							$display("No pio_rvalid on read of offset %0h at %0t", f1, $time);
							errors++;
						end else
							check_pio("pio_rdata", rd, f2);
					end
					"N": begin
						n = $fscanf(fd, "%h", f1);
						pio_access(1'b1, f1, '0, rd, v);
						if (v) begin
							$display("Unexpected pio_rvalid on read of unmapped offset %0h", f1);
							errors++;
						end
					end
					"I": wait_init_done();
					"A": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						alloc_once(f1[7:0], 1'b0, f2[7:0]);
					end
					"F": begin
						n = $fscanf(fd, "%h", f1);
						alloc_once(f1[7:0], 1'b1, '0);
					end
					"S": begin
						// Run of grants with consecutive pointers
						n = $fscanf(fd, "%h %h %h", f1, f2, f3);
						for (i = 0; i < f3; i++)
							alloc_once(f1[7:0], 1'b0, bm_pkg::buf_ptr_t'(f2 + i));
					end
					"D": begin
						n = $fscanf(fd, "%h", f1);
						free_once(f1[7:0]);
					end
					"L": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						link_write(f1[7:0], f2[7:0]);
					end
					"K": begin
						n = $fscanf(fd, "%h %h", f1, f2);
						link_read(f1[7:0], f2[7:0]);
					end
					default: begin
						$display("Unknown operation %c in the trace file", op);
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
source/bm_pkg.sv
source/bm_reg.sv
source/bm_freeb_list.sv
source/bm_link_list.sv
source/bm_top.sv
bench/bm_tb.sv

// ==== bench/bm_trace.txt ====
# W addr data | R addr expected | N unmapped addr | I wait init done | D ptr (free)
# A occupancy ptr | F occupancy (fails) | S occupancy first count | L ptr next | K ptr next
# reset state
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
N 6
F 00
# registers
W 5 000000a3
R 5 00000003
W 1 000000ff
R 1 00000000
W 4 00000055
R 4 00000000
W 5 00000000
# init and first grants
W 0 00000001
I
R 0 80000001
A 00 00
A 00 01
A 00 02
# freed pointers come back after the rest of the pool
D 02
D 00
S 00 03 fd
A 00 02
A 00 00
F 00
R 1 00000002
R 2 00000002
# re-init and admission with alpha 4
W 0 00000000
W 0 00000001
I
S 00 00 06
W 5 00000004
F 0f
A 0e 06
R 1 00000009
R 2 00000002
# link list
L 10 20
K 10 20
L 10 33
K 10 33
R 3 00000002
R 4 00000002
